// File: include/tl_rx_defines.svh
// receive write handler widths shared by the package and the RTL
`ifndef TL_RX_DEFINES_SVH
`define TL_RX_DEFINES_SVH

// double word and beat geometry
`define DW_W        32
`define BEAT_DW     8

// receive bus from the data-link layer
`define TLP_BUS_W   256

// header slice, top 4 DW of the header beat
`define HDR_W       128

// length field of DW0, 0 encodes 1024
`define LEN_W       10

// largest TLP is 1029 DW, 129 beats
`define BEAT_CNT_W  8

`define VC_CTRL_W   5   // valid, hdr write, status, has data

`endif

// File: source/tl_rx_pkg.sv
// receive write handler package with buffer classes, fsm states and VC port types
`default_nettype none

`include "tl_rx_defines.svh"

package tl_rx_pkg;

    typedef enum logic [1:0] {
        POSTED     = 2'b00,
        NON_POSTED = 2'b01,
        COMPLETION = 2'b10
    } buf_class_e;  // 2'b11 not used

    typedef enum logic [1:0] {
        ST_IDLE  = 2'b00,
        ST_HDR   = 2'b01,
        ST_DATA  = 2'b10,
        ST_CHECK = 2'b11
    } rx_state_e;

    // {fmt[2:0], type[4:0]} codes, ? bits are don't care in casez
    localparam logic [7:0] FT_MRD_32    = 8'b0000_0000;
    localparam logic [7:0] FT_MRD_64    = 8'b0010_0000;
    localparam logic [7:0] FT_MRDLK_32  = 8'b0000_0001;
    localparam logic [7:0] FT_MRDLK_64  = 8'b0010_0001;
    localparam logic [7:0] FT_MWR_32    = 8'b0100_0000;
    localparam logic [7:0] FT_MWR_64    = 8'b0110_0000;
    localparam logic [7:0] FT_IORD      = 8'b0000_0010;
    localparam logic [7:0] FT_IOWR      = 8'b0100_0010;
    localparam logic [7:0] FT_CFGRD0    = 8'b0000_0100;
    localparam logic [7:0] FT_CFGWR0    = 8'b0100_0100;
    localparam logic [7:0] FT_CFGRD1    = 8'b0000_0101;
    localparam logic [7:0] FT_CFGWR1    = 8'b0100_0101;
    localparam logic [7:0] FT_MSG       = 8'b0011_00??;   // routing in low bits
    localparam logic [7:0] FT_MSGD      = 8'b0111_00??;
    localparam logic [7:0] FT_CPL       = 8'b0000_1010;
    localparam logic [7:0] FT_CPLD      = 8'b0100_1010;
    localparam logic [7:0] FT_CPLLK     = 8'b0000_1011;
    localparam logic [7:0] FT_CPLDLK    = 8'b0100_1011;
    localparam logic [7:0] FT_FETCHADD  = 8'b01?0_1100;   // 32 or 64 bit address
    localparam logic [7:0] FT_SWAP      = 8'b01?0_1101;
    localparam logic [7:0] FT_CAS       = 8'b01?0_1110;

    // fmt[1:0], header size and data presence
    localparam logic [1:0] FMT_H3  = 2'b00;
    localparam logic [1:0] FMT_H4  = 2'b01;
    localparam logic [1:0] FMT_H3D = 2'b10;
    localparam logic [1:0] FMT_H4D = 2'b11;

    typedef struct packed {
        buf_class_e buf_class;
        logic       has_data;
    } tlp_info_t;

    typedef struct packed {
        logic      valid;
        logic      hdr_wr;
        rx_state_e status;      // next state of the sequencer
        logic      has_data;
    } vc_ctrl_t;

    typedef struct packed {
        logic [`HDR_W-1:0]     hdr;
        logic [`TLP_BUS_W-1:0] data;
        vc_ctrl_t              ctrl;
    } vc_port_t;

    typedef struct packed {
        logic p_hdr;
        logic p_data;
        logic np_hdr;
        logic np_data;
        logic cpl_hdr;
        logic cpl_data;
    } vc_full_t;

endpackage

`default_nettype wire

// File: source/tlp_hdr_decoder.sv
// header decoder, maps fmt/type to a buffer class and length to a beat count
`timescale 1ns/1ps
`default_nettype none

`include "tl_rx_defines.svh"

module tlp_hdr_decoder
    import tl_rx_pkg::*;
(
    input  wire                     i_clk,
    input  wire                     i_n_rst,
    input  wire                     i_sop_ld,       // header beat on the bus
    input  wire  [`TLP_BUS_W-1:0]   i_tlp,
    output tlp_info_t               o_info,
    output logic [`BEAT_CNT_W-1:0]  o_num_beats     // beats after the header beat
);

    logic [`HDR_W-1:0]  hdr;
    logic [`DW_W-1:0]   hdr_dw0;
    logic [2:0]         fmt;
    logic [4:0]         typ;
    logic               td;
    logic [`LEN_W-1:0]  len;
    logic [10:0]        len_dw;
    logic [10:0]        total_dw;   // up to 4 + 1 + 1024
    logic [10:0]        beats_m1;
    tlp_info_t          info_live;
    tlp_info_t          info_reg;

    assign hdr     = i_tlp[`TLP_BUS_W-1 -: `HDR_W];
    assign hdr_dw0 = hdr[`HDR_W-1 -: `DW_W];
    assign fmt     = hdr_dw0[31:29];
    assign typ     = hdr_dw0[28:24];
    assign td      = hdr_dw0[15];
    assign len     = hdr_dw0[`LEN_W-1:0];

    // class and data flag from the fmt/type byte
    always_comb begin
        info_live = '{buf_class: POSTED, has_data: 1'b0};
        casez ({fmt, typ})
            FT_MRD_32, FT_MRD_64, FT_MRDLK_32, FT_MRDLK_64,
            FT_IORD, FT_CFGRD0, FT_CFGRD1: begin
                info_live = '{buf_class: NON_POSTED, has_data: 1'b0};
            end
            FT_MWR_32, FT_MWR_64, FT_MSGD: begin
                info_live = '{buf_class: POSTED, has_data: 1'b1};
            end
            FT_IOWR, FT_CFGWR0, FT_CFGWR1,
            FT_FETCHADD, FT_SWAP, FT_CAS: begin
                info_live = '{buf_class: NON_POSTED, has_data: 1'b1};
            end
            FT_MSG: begin
                info_live = '{buf_class: POSTED, has_data: 1'b0};
            end
            FT_CPL, FT_CPLLK: begin
                info_live = '{buf_class: COMPLETION, has_data: 1'b0};
            end
            FT_CPLD, FT_CPLDLK: begin
                info_live = '{buf_class: COMPLETION, has_data: 1'b1};
            end
            default: begin
                info_live = '{buf_class: POSTED, has_data: 1'b0};
            end
        endcase
    end

    assign len_dw = (len == '0) ? 11'd1024 : 11'(len);

    // header DWs, digest DW, payload DWs
    always_comb begin
        case (fmt[1:0])
            FMT_H3:  total_dw = 11'd3 + 11'(td);
            FMT_H4:  total_dw = 11'd4 + 11'(td);
            FMT_H3D: total_dw = 11'd3 + 11'(td) + len_dw;
            FMT_H4D: total_dw = 11'd4 + 11'(td) + len_dw;
            default: total_dw = 11'd3;
        endcase
    end

    // ceil(total_dw / 8) - 1
    assign beats_m1    = (total_dw - 11'd1) / `BEAT_DW;
    assign o_num_beats = beats_m1[`BEAT_CNT_W-1:0];

    always_ff @(posedge i_clk or negedge i_n_rst) begin
        if (!i_n_rst) begin
            info_reg <= '{buf_class: POSTED, has_data: 1'b0};
        end else if (i_sop_ld) begin
            info_reg <= info_live;
        end
    end

    // live decode while the header beat is on the bus
    assign o_info = i_sop_ld ? info_live : info_reg;

endmodule

`default_nettype wire

// File: source/rx_sequencer.sv
// receive sequencer, walks a TLP through header, data and check states
`timescale 1ns/1ps
`default_nettype none

`include "tl_rx_defines.svh"

module rx_sequencer
    import tl_rx_pkg::*;
(
    input  wire                     i_clk,
    input  wire                     i_n_rst,
    input  wire                     i_sop,
    input  wire                     i_blk,
    input  wire                     i_rcv_error,
    input  wire  tlp_info_t         i_info,
    input  wire  [`BEAT_CNT_W-1:0]  i_num_beats,
    output logic                    o_sop_ld,
    output vc_ctrl_t                o_ctrl
);

    rx_state_e              state;
    rx_state_e              next_state;
    logic [`BEAT_CNT_W-1:0] beat_cnt;
    logic                   accept;
    logic                   last_beat;
    logic                   valid;

    // load on any sop seen in idle so blocking is judged on the new class
    assign o_sop_ld  = (state == ST_IDLE) && i_sop;
    assign accept    = o_sop_ld && !i_blk;     // blocked sop is dropped
    assign last_beat = (beat_cnt == '0);

    always_ff @(posedge i_clk or negedge i_n_rst) begin
        if (!i_n_rst) begin
            state <= ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // remaining beats after the current one
    always_ff @(posedge i_clk or negedge i_n_rst) begin
        if (!i_n_rst) begin
            beat_cnt <= '0;
        end else if (accept) begin
            beat_cnt <= i_num_beats;
        end else if (!last_beat) begin
            beat_cnt <= beat_cnt - 1'b1;
        end
    end

    always_comb begin
        next_state = state;
        valid      = 1'b0;
        case (state)
            ST_IDLE: begin
                if (accept) begin
                    next_state = ST_HDR;
                end
            end
            ST_HDR: begin
                if (i_blk || i_rcv_error) begin
                    next_state = ST_IDLE;     // abandon, no write
                end else if (!last_beat) begin
                    next_state = ST_DATA;
                end else begin
                    next_state = ST_CHECK;    // single beat TLP
                end
            end
            ST_DATA: begin
                if (i_blk) begin
                    next_state = ST_IDLE;
                end else if (last_beat) begin
                    next_state = ST_CHECK;
                end
            end
            ST_CHECK: begin
                next_state = ST_IDLE;
                valid      = !i_rcv_error;    // commit unless flagged
            end
            default: begin
                next_state = ST_IDLE;
            end
        endcase
    end

    assign o_ctrl = '{
        valid:    valid,
        hdr_wr:   accept,
        status:   next_state,
        has_data: i_info.has_data
    };

endmodule

`default_nettype wire

// File: source/vc_write_demux.sv
// VC write demux, blocking from full flags and routing of the beat to its class port
`timescale 1ns/1ps
`default_nettype none

`include "tl_rx_defines.svh"

module vc_write_demux
    import tl_rx_pkg::*;
(
    input  wire  tlp_info_t         i_info,
    input  wire  vc_full_t          i_full,
    input  wire  [`TLP_BUS_W-1:0]   i_tlp,
    input  wire  vc_ctrl_t          i_ctrl,
    output logic                    o_blk,
    output vc_port_t                o_posted,
    output vc_port_t                o_non_posted,
    output vc_port_t                o_completion
);

    vc_port_t beat;

    // either buffer of the class being full stops the TLP
    always_comb begin
        case (i_info.buf_class)
            POSTED:     o_blk = i_full.p_hdr   | i_full.p_data;
            NON_POSTED: o_blk = i_full.np_hdr  | i_full.np_data;
            COMPLETION: o_blk = i_full.cpl_hdr | i_full.cpl_data;
            default:    o_blk = 1'b0;
        endcase
    end

    assign beat = '{
        hdr:  i_tlp[`TLP_BUS_W-1 -: `HDR_W],
        data: i_tlp,
        ctrl: i_ctrl
    };

    always_comb begin
        o_posted     = '0;
        o_non_posted = '0;
        o_completion = '0;
        case (i_info.buf_class)
            POSTED:     o_posted     = beat;
            NON_POSTED: o_non_posted = beat;
            COMPLETION: o_completion = beat;
            default: begin
                // unused class code, all ports idle
            end
        endcase
    end

endmodule

`default_nettype wire

// File: source/tl_rx_write_handler.sv
// transaction layer receive write handler, routes incoming TLPs to VC buffers
`timescale 1ns/1ps
`default_nettype none

`include "tl_rx_defines.svh"

module tl_rx_write_handler
    import tl_rx_pkg::*;
(
    input  wire                     i_clk,
    input  wire                     i_n_rst,
    input  wire                     i_dll_rcv_sop,
    input  wire  [`TLP_BUS_W-1:0]   i_dll_rcv_tlp,
    input  wire  vc_full_t          i_vc0_full,
    input  wire                     i_rcv_error,
    output logic                    o_tlp_rcv_blk,
    output vc_port_t                o_w_posted,
    output vc_port_t                o_w_non_posted,
    output vc_port_t                o_w_completion
);

    tlp_info_t              info;
    logic [`BEAT_CNT_W-1:0] num_beats;
    logic                   sop_ld;
    vc_ctrl_t               ctrl;

    tlp_hdr_decoder u_hdr_decoder (
        .i_clk       (i_clk),
        .i_n_rst     (i_n_rst),
        .i_sop_ld    (sop_ld),
        .i_tlp       (i_dll_rcv_tlp),
        .o_info      (info),
        .o_num_beats (num_beats)
    );

    rx_sequencer u_sequencer (
        .i_clk       (i_clk),
        .i_n_rst     (i_n_rst),
        .i_sop       (i_dll_rcv_sop),
        .i_blk       (o_tlp_rcv_blk),
        .i_rcv_error (i_rcv_error),
        .i_info      (info),
        .i_num_beats (num_beats),
        .o_sop_ld    (sop_ld),
        .o_ctrl      (ctrl)
    );

    vc_write_demux u_demux (
        .i_info       (info),
        .i_full       (i_vc0_full),
        .i_tlp        (i_dll_rcv_tlp),
        .i_ctrl       (ctrl),
        .o_blk        (o_tlp_rcv_blk),
        .o_posted     (o_w_posted),
        .o_non_posted (o_w_non_posted),
        .o_completion (o_w_completion)
    );

endmodule

`default_nettype wire

// File: verification/tl_rx_write_handler_assert.sv
// bound protocol checks on the VC write ports of the receive write handler
`timescale 1ns/1ps
`default_nettype none

`include "tl_rx_defines.svh"

module tl_rx_write_handler_assert
    import tl_rx_pkg::*;
(
    input wire           i_clk,
    input wire           i_n_rst,
    input wire vc_port_t i_posted,
    input wire vc_port_t i_non_posted,
    input wire vc_port_t i_completion
);

    logic       valid_any;
    logic       hdr_wr_any;
    logic [2:0] ctrl_busy;  // one bit per port

    assign valid_any  = i_posted.ctrl.valid | i_non_posted.ctrl.valid | i_completion.ctrl.valid;
    assign hdr_wr_any = i_posted.ctrl.hdr_wr | i_non_posted.ctrl.hdr_wr
                      | i_completion.ctrl.hdr_wr;
    assign ctrl_busy  = {|i_posted.ctrl, |i_non_posted.ctrl, |i_completion.ctrl};

    // commit strobe lasts one cycle
    assert property (@(posedge i_clk) disable iff (!i_n_rst) valid_any |=> !valid_any)
        else $error("valid high for two cycles in a row");

    assert property (@(posedge i_clk) disable iff (!i_n_rst) $onehot0(ctrl_busy))
        else $error("control word active on more than one port");

    assert property (@(posedge i_clk) disable iff (!i_n_rst) !(hdr_wr_any && valid_any))
        else $error("header write and valid in the same cycle");

endmodule

bind tl_rx_write_handler tl_rx_write_handler_assert u_assert (
    .i_clk        (i_clk),
    .i_n_rst      (i_n_rst),
    .i_posted     (o_w_posted),
    .i_non_posted (o_w_non_posted),
    .i_completion (o_w_completion)
);

`default_nettype wire

// File: verification/tb_tl_rx_write_handler.sv
// testbench for the receive write handler, table of TLPs checked against a reference model
`timescale 1ns/1ps
`default_nettype none

`include "tl_rx_defines.svh"

module tb_tl_rx_write_handler
    import tl_rx_pkg::*;
();

    localparam int NUM_ENTRIES = 23;
    localparam int MAX_CYCLES  = NUM_ENTRIES * 140;  // longest TLP takes 133 cycles

    typedef struct packed {
        logic [7:0] ft;         // {fmt, type}
        logic [9:0] len;
        logic       td;
        logic [5:0] full;       // vc_full_t flags to apply
        logic [7:0] full_at;    // cycle after sop where they appear
        logic       err;        // error flag in the check cycle
        buf_class_e cls;
        logic       hd;
    } entry_t;

    logic                   clk;
    logic                   n_rst;
    logic                   sop;
    logic [`TLP_BUS_W-1:0]  tlp;
    vc_full_t               vc0_full;
    logic                   rcv_error;
    logic                   blk;
    vc_port_t               w_posted;
    vc_port_t               w_non_posted;
    vc_port_t               w_completion;

    entry_t tbl [NUM_ENTRIES];
    integer seed;
    int     errors;
    int     checks;
    int     cycles;
    int     i;

    tl_rx_write_handler uut (
        .i_clk          (clk),
        .i_n_rst        (n_rst),
        .i_dll_rcv_sop  (sop),
        .i_dll_rcv_tlp  (tlp),
        .i_vc0_full     (vc0_full),
        .i_rcv_error    (rcv_error),
        .o_tlp_rcv_blk  (blk),
        .o_w_posted     (w_posted),
        .o_w_non_posted (w_non_posted),
        .o_w_completion (w_completion)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: test did not finish within %0d cycles", MAX_CYCLES);
            $display("checks: %0d, errors: %0d", checks, errors);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic load_table();
        //         ft      len     td    full   at     err   class       hd
        tbl[0]  = '{8'h00, 10'd1,  1'b0, 6'h00, 8'd0,  1'b0, NON_POSTED, 1'b0}; // MRd 32
        tbl[1]  = '{8'h40, 10'd1,  1'b0, 6'h00, 8'd0,  1'b0, POSTED,     1'b1}; // MWr 32
        tbl[2]  = '{8'h60, 10'd5,  1'b1, 6'h00, 8'd0,  1'b0, POSTED,     1'b1}; // MWr 64
        tbl[3]  = '{8'h40, 10'd12, 1'b0, 6'h00, 8'd0,  1'b0, POSTED,     1'b1};
        tbl[4]  = '{8'h60, 10'd12, 1'b1, 6'h00, 8'd0,  1'b0, POSTED,     1'b1};
        tbl[5]  = '{8'h02, 10'd1,  1'b0, 6'h00, 8'd0,  1'b0, NON_POSTED, 1'b0}; // IORd
        tbl[6]  = '{8'h42, 10'd1,  1'b1, 6'h00, 8'd0,  1'b0, NON_POSTED, 1'b1}; // IOWr
        tbl[7]  = '{8'h04, 10'd1,  1'b0, 6'h00, 8'd0,  1'b0, NON_POSTED, 1'b0}; // CfgRd0
        tbl[8]  = '{8'h45, 10'd1,  1'b0, 6'h00, 8'd0,  1'b0, NON_POSTED, 1'b1}; // CfgWr1
        tbl[9]  = '{8'h30, 10'd1,  1'b1, 6'h00, 8'd0,  1'b0, POSTED,     1'b0}; // Msg
        tbl[10] = '{8'h73, 10'd5,  1'b0, 6'h00, 8'd0,  1'b0, POSTED,     1'b1}; // MsgD
        tbl[11] = '{8'h0A, 10'd1,  1'b0, 6'h00, 8'd0,  1'b0, COMPLETION, 1'b0}; // Cpl
        tbl[12] = '{8'h4A, 10'd0,  1'b1, 6'h00, 8'd0,  1'b0, COMPLETION, 1'b1}; // CplD 1024 DW
        tbl[13] = '{8'h6C, 10'd1,  1'b0, 6'h00, 8'd0,  1'b0, NON_POSTED, 1'b1}; // FetchAdd
        tbl[14] = '{8'h4E, 10'd5,  1'b1, 6'h00, 8'd0,  1'b0, NON_POSTED, 1'b1}; // CAS
        // back-pressure and error cases
        tbl[15] = '{8'h40, 10'd1,  1'b0, 6'h20, 8'd0,  1'b0, POSTED,     1'b1}; // p hdr full
        tbl[16] = '{8'h4A, 10'd12, 1'b0, 6'h01, 8'd0,  1'b0, COMPLETION, 1'b1}; // cpl data
        tbl[17] = '{8'h00, 10'd1,  1'b0, 6'h04, 8'd0,  1'b0, NON_POSTED, 1'b0}; // np data
        tbl[18] = '{8'h40, 10'd5,  1'b0, 6'h00, 8'd0,  1'b1, POSTED,     1'b1};
        tbl[19] = '{8'h00, 10'd1,  1'b0, 6'h00, 8'd0,  1'b0, NON_POSTED, 1'b0};
        tbl[20] = '{8'h60, 10'd0,  1'b1, 6'h10, 8'd40, 1'b0, POSTED,     1'b1}; // full mid TLP
        tbl[21] = '{8'h60, 10'd0,  1'b0, 6'h00, 8'd0,  1'b0, POSTED,     1'b1};
        tbl[22] = '{8'h40, 10'd1,  1'b0, 6'h08, 8'd0,  1'b0, POSTED,     1'b1}; // np full only
    endtask

    // beats after the header beat, ceil(total_dw / 8) - 1
    function automatic int expected_beats(input logic [7:0] ft, input logic [9:0] len,
                                          input logic td);
        int total_dw;
        total_dw = ft[5] ? 4 : 3;           // fmt[0] picks a 4 DW header
        total_dw = total_dw + int'(td);     // digest DW
        if (ft[6]) begin
            total_dw = total_dw + ((len == 0) ? 1024 : int'(len));
        end
        return (total_dw + `BEAT_DW - 1) / `BEAT_DW - 1;
    endfunction

    function automatic logic class_is_full(input buf_class_e cls, input vc_full_t f);
        case (cls)
            POSTED:     return f.p_hdr | f.p_data;
            NON_POSTED: return f.np_hdr | f.np_data;
            COMPLETION: return f.cpl_hdr | f.cpl_data;
            default:    return 1'b0;
        endcase
    endfunction

    function automatic logic [`TLP_BUS_W-1:0] random_beat();
        logic [`TLP_BUS_W-1:0] b;
        for (int k = 0; k < `BEAT_DW; k++) begin
            b[k*`DW_W +: `DW_W] = $random(seed);
        end
        return b;
    endfunction

    task automatic flag_mismatch(input string msg);
        errors++;
        $display("MISMATCH at %0t: %s", $time, msg);
    endtask

    task automatic check_ports(input string where, input buf_class_e cls, input logic hd,
                               input logic [`TLP_BUS_W-1:0] beat, input logic exp_hw,
                               input logic exp_valid, input logic exp_blk,
                               input rx_state_e exp_status, output logic got_valid);
        vc_port_t sel;
        logic     others_zero;
        case (cls)
            POSTED: begin
                sel         = w_posted;
                others_zero = (w_non_posted == '0) && (w_completion == '0);
            end
            NON_POSTED: begin
                sel         = w_non_posted;
                others_zero = (w_posted == '0) && (w_completion == '0);
            end
            default: begin
                sel         = w_completion;
                others_zero = (w_posted == '0) && (w_non_posted == '0);
            end
        endcase
        got_valid = sel.ctrl.valid;
        checks++;
        assert (others_zero) else flag_mismatch({where, ": port of another class not zero"});
        assert (sel.data == beat && sel.hdr == beat[`TLP_BUS_W-1 -: `HDR_W])
            else flag_mismatch({where, ": beat or header slice differs"});
        assert (sel.ctrl.has_data == hd)
            else flag_mismatch($sformatf("%s: has_data exp %0b got %0b", where, hd,
                                         sel.ctrl.has_data));
        assert (sel.ctrl.hdr_wr == exp_hw)
            else flag_mismatch($sformatf("%s: hdr_wr exp %0b got %0b", where, exp_hw,
                                         sel.ctrl.hdr_wr));
        assert (sel.ctrl.valid == exp_valid)
            else flag_mismatch($sformatf("%s: valid exp %0b got %0b", where, exp_valid,
                                         sel.ctrl.valid));
        assert (sel.ctrl.status == exp_status)
            else flag_mismatch($sformatf("%s: status exp %0d got %0d", where, exp_status,
                                         sel.ctrl.status));
        assert (blk == exp_blk)
            else flag_mismatch($sformatf("%s: blk exp %0b got %0b", where, exp_blk, blk));
    endtask

    task automatic run_entry(input int idx, input entry_t e);
        logic [`TLP_BUS_W-1:0] beat;
        vc_full_t              full_now;
        logic                  exp_blk;
        logic                  alive;
        logic                  got_valid;
        rx_state_e             exp_status;
        int                    valid_cyc;
        int                    pulses;
        string                 where;
        valid_cyc = expected_beats(e.ft, e.len, e.td) + 2;  // header, data beats, check
        pulses    = 0;
        alive     = 1'b1;
        for (int c = 0; c <= valid_cyc + 2; c++) begin
            @(posedge clk);
            #1;
            beat = random_beat();
            if (c == 0) begin
                beat[`TLP_BUS_W-1 -: `DW_W] = {e.ft, 8'h00, e.td, 5'h00, e.len};
            end
            full_now  = (c >= e.full_at) ? e.full : '0;
            sop       = (c == 0);
            tlp       = beat;
            vc0_full  = full_now;
            rcv_error = e.err && (c == valid_cyc);
            exp_blk   = class_is_full(e.cls, full_now);
            if (exp_blk && c < valid_cyc) begin
                alive = 1'b0;   // dropped sop or abandoned TLP
            end
            // state the sequencer moves to at the end of this cycle
            if (!alive) begin
                exp_status = ST_IDLE;
            end else if (c == 0) begin
                exp_status = ST_HDR;
            end else if (c < valid_cyc - 1) begin
                exp_status = ST_DATA;
            end else if (c == valid_cyc - 1) begin
                exp_status = ST_CHECK;
            end else begin
                exp_status = ST_IDLE;
            end
            @(negedge clk);
            where = $sformatf("entry %0d cycle %0d", idx, c);
            check_ports(where, e.cls, e.hd, beat, (c == 0) && !exp_blk,
                        (c == valid_cyc) && alive && !e.err, exp_blk, exp_status,
                        got_valid);
            pulses += int'(got_valid);
        end
        checks++;
        assert (pulses == ((alive && !e.err) ? 1 : 0))
            else flag_mismatch($sformatf("entry %0d: %0d valid pulses", idx, pulses));
    endtask

    initial begin
        seed      = 32'h1f15;
        errors    = 0;
        checks    = 0;
        cycles    = 0;
        clk       = 1'b0;
        n_rst     = 1'b0;
        sop       = 1'b0;
        tlp       = '0;
        vc0_full  = '0;
        rcv_error = 1'b0;
        load_table();
        repeat (2) @(posedge clk);
        #1;
        n_rst = 1'b1;
        for (i = 0; i < NUM_ENTRIES; i++) begin
            run_entry(i, tbl[i]);
        end
        @(posedge clk);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tl_rx_write_handler.f
+incdir+include
source/tl_rx_pkg.sv
source/tlp_hdr_decoder.sv
source/rx_sequencer.sv
source/vc_write_demux.sv
source/tl_rx_write_handler.sv
verification/tl_rx_write_handler_assert.sv
verification/tb_tl_rx_write_handler.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_tl_rx_write_handler
FILELIST  := tl_rx_write_handler.f
OBJ_DIR   := obj_dir
PASS_MSG  := NO ERRORS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check the result"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
